//--- hw/timetag_pkg.sv
package timetag_pkg;

	localparam int NUM_CHANNELS = 4;
	localparam int SAMPLE_BYTES = 6;
	localparam int STAMP_BITS = 43;

	// bit positions inside the data byte of a timer command
	localparam int TMR_START = 0;
	localparam int TMR_STOP = 1;
	localparam int TMR_CLEAR = 2;

	// bit positions inside the data byte of a sequencer-run command
	localparam int SEQ_START = 0;
	localparam int SEQ_STOP = 1;

	// targets 6 and 7 have no receiver and fall through silently
	typedef enum logic [2:0] {
		tgt_timer = 3'd0,
		tgt_seq_run = 3'd1,
		tgt_period0 = 3'd2,
		tgt_period1 = 3'd3,
		tgt_period2 = 3'd4,
		tgt_period3 = 3'd5
	} cmd_target_t;

	typedef struct packed {
		cmd_target_t target;
		logic [7:0] data;
	} cmd_t;

	// 48 bits, sent to the host most significant byte first
	typedef struct packed {
		logic lost;
		logic [NUM_CHANNELS-1:0] channels;
		logic [STAMP_BITS-1:0] stamp;
	} sample_t;

endpackage

//--- hw/cmd_parser.sv
module cmd_parser (
	input logic clk,
	input logic rst_n,
	input logic cmd_wr,
	input logic [7:0] cmd_in,
	output logic cmd_valid,
	output timetag_pkg::cmd_t cmd
);

	typedef enum logic {
		st_idle,
		st_data
	} state_t;

	state_t state;
	timetag_pkg::cmd_target_t target_q;
	logic [2:0] target_bits;

	// a target byte above 7 maps onto the unused code 7 so no receiver reacts
	assign target_bits = (cmd_in[7:3] != 5'd0) ? 3'd7 : cmd_in[2:0];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			cmd_valid <= 1'b0;
		end
		else
		begin
			cmd_valid <= 1'b0;
			if (cmd_wr)
			begin
				if (state == st_idle)
					state <= st_data;
				else
				begin
					state <= st_idle;
					cmd_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd_wr && state == st_idle)
			target_q <= timetag_pkg::cmd_target_t'(target_bits);
		if (cmd_wr && state == st_data)
		begin
			cmd.target <= target_q;
			cmd.data <= cmd_in;
		end
	end

endmodule

//--- hw/run_control.sv
module run_control (
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	input timetag_pkg::cmd_t cmd,
	output logic timer_run,
	output logic seq_run,
	output logic time_clear
);

	logic timer_hit;
	logic seq_hit;

	assign timer_hit = cmd_valid && (cmd.target == timetag_pkg::tgt_timer);
	assign seq_hit = cmd_valid && (cmd.target == timetag_pkg::tgt_seq_run);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			timer_run <= 1'b0;
			seq_run <= 1'b0;
			time_clear <= 1'b0;
		end
		else
		begin
			// stop wins when a command carries both bits
			if (timer_hit)
				timer_run <= (timer_run | cmd.data[timetag_pkg::TMR_START]) &
					~cmd.data[timetag_pkg::TMR_STOP];
			if (seq_hit)
				seq_run <= (seq_run | cmd.data[timetag_pkg::SEQ_START]) &
					~cmd.data[timetag_pkg::SEQ_STOP];
			time_clear <= timer_hit && cmd.data[timetag_pkg::TMR_CLEAR];
		end
	end

endmodule

//--- hw/pulse_sequencer.sv
module pulse_sequencer #(
	parameter int CHANNEL = 0
) (
	input logic clk,
	input logic rst_n,
	input logic seq_run,
	input logic cmd_valid,
	input timetag_pkg::cmd_t cmd,
	output logic laser_en
);

	localparam logic [2:0] TARGET_CODE = 3'(CHANNEL + 2);

	logic [7:0] period;
	logic [7:0] count;
	logic running;

	assign running = seq_run && (period != 8'd0);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			period <= 8'd0;
		else if (cmd_valid && (cmd.target == timetag_pkg::cmd_target_t'(TARGET_CODE)))
			period <= cmd.data;
	end

	// count runs 0 to period-1, so the output flips every period cycles
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			count <= 8'd0;
			laser_en <= 1'b0;
		end
		else if (!running)
		begin
			count <= 8'd0;
			laser_en <= 1'b0;
		end
		else if (count >= period - 8'd1)
		begin
			// >= covers a period shortened while the counter is past it
			count <= 8'd0;
			laser_en <= ~laser_en;
		end
		else
			count <= count + 8'd1;
	end

endmodule

//--- hw/detector_timestamper.sv
module detector_timestamper (
	input logic clk,
	input logic rst_n,
	input logic [timetag_pkg::NUM_CHANNELS-1:0] detectors,
	input logic timer_run,
	input logic time_clear,
	input logic full,
	output logic sample_valid,
	output timetag_pkg::sample_t sample
);

	localparam int N = timetag_pkg::NUM_CHANNELS;

	logic [N-1:0] sync1;
	logic [N-1:0] sync2;
	logic [N-1:0] sync2_d;
	logic [N-1:0] edge_mask;
	logic [timetag_pkg::STAMP_BITS-1:0] time_count;
	logic lost;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync1 <= '0;
			sync2 <= '0;
			sync2_d <= '0;
			edge_mask <= '0;
			sample_valid <= 1'b0;
			time_count <= '0;
			lost <= 1'b0;
		end
		else
		begin
			sync1 <= detectors;
			sync2 <= sync1;
			sync2_d <= sync2;
			edge_mask <= sync2 & ~sync2_d;
			sample_valid <= timer_run && ((sync2 & ~sync2_d) != '0);
			if (time_clear)
				time_count <= '0;
			else if (timer_run)
				time_count <= time_count + 1'b1;
			// the flag rides on the next accepted sample, then drops
			if (sample_valid)
				lost <= full;
		end
	end

	// stamp is taken live so it equals the count in the sample_valid cycle
	assign sample.lost = lost;
	assign sample.channels = edge_mask;
	assign sample.stamp = time_count;

endmodule

//--- hw/sample_buffer.sv
module sample_buffer #(
	parameter int DEPTH = 8,
	parameter type payload_t = logic [47:0]
) (
	input logic clk,
	input logic rst_n,
	input logic push,
	input payload_t push_data,
	output logic full,
	input logic pop,
	output logic not_empty,
	output payload_t head,
	input logic request_length,
	output logic [15:0] length
);

	localparam int AW = $clog2(DEPTH);

	payload_t mem [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [15:0] count;
	logic accept;

	// pointers carry one wrap bit above the address
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign not_empty = (wr_ptr != rd_ptr);
	assign head = mem[rd_ptr[AW-1:0]];
	assign accept = push && !full;

	always_ff @(posedge clk)
	begin
		if (accept)
			mem[wr_ptr[AW-1:0]] <= push_data;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= 16'd0;
			length <= 16'd0;
		end
		else
		begin
			if (accept)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && not_empty)
				rd_ptr <= rd_ptr + 1'b1;
			if (request_length)
			begin
				// a write in the request cycle opens the new period
				length <= count;
				count <= accept ? 16'd1 : 16'd0;
			end
			else if (accept)
				count <= count + 16'd1;
		end
	end

endmodule

//--- hw/sample_serializer.sv
module sample_serializer (
	input logic clk,
	input logic rst_n,
	input logic not_empty,
	input timetag_pkg::sample_t head,
	output logic pop,
	output logic data_rdy,
	output logic [7:0] data,
	input logic data_ack
);

	localparam int IW = $clog2(timetag_pkg::SAMPLE_BYTES);
	localparam logic [IW-1:0] LAST_IDX = IW'(timetag_pkg::SAMPLE_BYTES - 1);

	logic [IW-1:0] byte_idx;
	logic [8*timetag_pkg::SAMPLE_BYTES-1:0] head_bits;
	logic xfer;

	assign head_bits = head;
	assign xfer = data_rdy && data_ack;
	// index 0 selects the most significant byte
	assign data = head_bits[8*(timetag_pkg::SAMPLE_BYTES - 1 - int'(byte_idx)) +: 8];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			byte_idx <= '0;
			data_rdy <= 1'b0;
			pop <= 1'b0;
		end
		else
		begin
			pop <= 1'b0;
			if (xfer)
			begin
				if (byte_idx == LAST_IDX)
				begin
					byte_idx <= '0;
					data_rdy <= 1'b0;
					pop <= 1'b1;
				end
				else
					byte_idx <= byte_idx + 1'b1;
			end
			else if (!data_rdy && !pop && not_empty)
				// not_empty is stale while pop is high, so wait one more cycle
				data_rdy <= 1'b1;
		end
	end

endmodule

//--- hw/timetag_top.sv
module timetag_top #(
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rst_n,
	input logic cmd_wr,
	input logic [7:0] cmd_in,
	input logic request_length,
	output logic [15:0] length,
	output logic data_rdy,
	output logic [7:0] data,
	input logic data_ack,
	input logic [timetag_pkg::NUM_CHANNELS-1:0] detectors,
	output logic [timetag_pkg::NUM_CHANNELS-1:0] laser_en
);

	logic cmd_valid;
	timetag_pkg::cmd_t cmd;
	logic timer_run;
	logic seq_run;
	logic time_clear;
	logic sample_valid;
	timetag_pkg::sample_t sample;
	logic full;
	logic not_empty;
	timetag_pkg::sample_t head;
	logic pop;

	cmd_parser parser0 (
		.clk(clk), .rst_n(rst_n), .cmd_wr(cmd_wr), .cmd_in(cmd_in),
		.cmd_valid(cmd_valid), .cmd(cmd)
	);

	run_control ctrl0 (
		.clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
		.timer_run(timer_run), .seq_run(seq_run), .time_clear(time_clear)
	);

	for (genvar i = 0; i < timetag_pkg::NUM_CHANNELS; i++)
	begin : g_seq
		pulse_sequencer #(.CHANNEL(i)) seq (
			.clk(clk), .rst_n(rst_n), .seq_run(seq_run), .cmd_valid(cmd_valid),
			.cmd(cmd), .laser_en(laser_en[i])
		);
	end

	detector_timestamper stamper0 (
		.clk(clk), .rst_n(rst_n), .detectors(detectors), .timer_run(timer_run),
		.time_clear(time_clear), .full(full), .sample_valid(sample_valid), .sample(sample)
	);

	sample_buffer #(.DEPTH(FIFO_DEPTH), .payload_t(timetag_pkg::sample_t)) buffer0 (
		.clk(clk), .rst_n(rst_n), .push(sample_valid), .push_data(sample), .full(full),
		.pop(pop), .not_empty(not_empty), .head(head),
		.request_length(request_length), .length(length)
	);

	sample_serializer ser0 (
		.clk(clk), .rst_n(rst_n), .not_empty(not_empty), .head(head), .pop(pop),
		.data_rdy(data_rdy), .data(data), .data_ack(data_ack)
	);

endmodule

//--- verif/timetag_sva.sv
module timetag_sva (
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	input timetag_pkg::cmd_t cmd,
	input logic timer_run,
	input logic seq_run,
	input logic pop,
	input logic not_empty,
	input logic data_rdy,
	input logic data_ack,
	input logic [7:0] data
);

	logic timer_both;
	logic seq_both;

	assign timer_both = cmd_valid && (cmd.target == timetag_pkg::tgt_timer) &&
		cmd.data[timetag_pkg::TMR_START] && cmd.data[timetag_pkg::TMR_STOP];
	assign seq_both = cmd_valid && (cmd.target == timetag_pkg::tgt_seq_run) &&
		cmd.data[timetag_pkg::SEQ_START] && cmd.data[timetag_pkg::SEQ_STOP];

	// a byte on offer holds until the host takes it
	data_held: assert property (@(posedge clk) disable iff (!rst_n)
		data_rdy && !data_ack |=> data_rdy && $stable(data))
		else $error("data changed or data_rdy fell before data_ack");

	timer_stop_wins: assert property (@(posedge clk) disable iff (!rst_n)
		timer_both |=> !timer_run)
		else $error("timer start and stop in one command left the timer running");

	seq_stop_wins: assert property (@(posedge clk) disable iff (!rst_n)
		seq_both |=> !seq_run)
		else $error("sequencer start and stop in one command left seq_run high");

	pop_needs_data: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> not_empty)
		else $error("pop while the sample buffer is empty");

endmodule

bind timetag_top timetag_sva sva0 (
	.clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
	.timer_run(timer_run), .seq_run(seq_run), .pop(pop), .not_empty(not_empty),
	.data_rdy(data_rdy), .data_ack(data_ack), .data(data)
);

//--- verif/timetag_tb.sv
module timetag_tb;

	logic clk = 1'b0;
	logic rst_n;
	logic cmd_wr;
	logic [7:0] cmd_in;
	logic request_length;
	logic [15:0] length;
	logic data_rdy;
	logic [7:0] data;
	logic data_ack;
	logic [timetag_pkg::NUM_CHANNELS-1:0] detectors;
	logic [timetag_pkg::NUM_CHANNELS-1:0] laser_en;

	logic [7:0] ops[$];
	int arg_a[$];
	int arg_b[$];
	timetag_pkg::sample_t exp_q[$];
	longint cyc = 0;
	longint clear_ref;
	longint budget;
	logic [31:0] rng;
	logic timer_on;
	logic seq_on;
	logic lost_pending;
	int accepted;
	int errors;
	int checks;
	bit loaded = 1'b0;

	timetag_top dut0 (
		.clk(clk), .rst_n(rst_n), .cmd_wr(cmd_wr), .cmd_in(cmd_in),
		.request_length(request_length), .length(length), .data_rdy(data_rdy),
		.data(data), .data_ack(data_ack), .detectors(detectors), .laser_en(laser_en)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 64'd1;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic longint op_cycles(input logic [7:0] op, input int a, input int b);
		case (op)
			"C": return 6;
			"D": return longint'(b) + 8;
			"H": return longint'(a);
			"R": return longint'(a) * 60;
			"Q": return 4;
			"S": return 1300;
			default: return 0;
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		checks++;
		if (got != want)
		begin
			$display("[ERROR] %0t %s: expected %0h, got %0h", $time, name, want, got);
			errors++;
		end
	endtask

	task automatic send_command(input int target, input int value);
		cmd_wr = 1'b1;
		cmd_in = 8'(target);
		@(negedge clk);
		cmd_in = 8'(value);
		// stamps after a clear count from the cycle of this data byte
		if (target == 0 && value[timetag_pkg::TMR_CLEAR])
			clear_ref = cyc;
		if (target == 0)
			timer_on = (timer_on | value[timetag_pkg::TMR_START]) &
				~value[timetag_pkg::TMR_STOP];
		if (target == 1)
			seq_on = (seq_on | value[timetag_pkg::SEQ_START]) &
				~value[timetag_pkg::SEQ_STOP];
		@(negedge clk);
		cmd_wr = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic pulse_detector(input int mask, input int gap);
		timetag_pkg::sample_t s;
		repeat (gap) @(negedge clk);
		detectors = 4'(mask);
		if (timer_on)
		begin
			s.channels = 4'(mask);
			s.stamp = 43'(cyc - clear_ref);
			s.lost = lost_pending;
			// the model buffer mirrors the DUT, since reads always drain whole samples
			if (exp_q.size() >= dut0.FIFO_DEPTH)
				lost_pending = 1'b1;
			else
			begin
				lost_pending = 1'b0;
				exp_q.push_back(s);
				accepted++;
			end
		end
		repeat (2) @(negedge clk);
		detectors = '0;
		repeat (4) @(negedge clk);
	endtask

	task automatic read_samples(input int n);
		logic [47:0] got;
		timetag_pkg::sample_t rcv;
		timetag_pkg::sample_t want;
		int wait_cycles;
		int i;
		int b;
		for (i = 0; i < n; i++)
		begin
			for (b = 0; b < timetag_pkg::SAMPLE_BYTES; b++)
			begin
				wait_cycles = 0;
				while (!data_rdy && wait_cycles < 200)
				begin
					@(negedge clk);
					wait_cycles++;
				end
				if (!data_rdy)
				begin
					$display("%0t: the DUT offered no byte for sample %0d", $time, i);
					errors++;
					return;
				end
				rng = xorshift32(rng);
				repeat (int'(rng[1:0])) @(negedge clk);
				got = {got[39:0], data};
				data_ack = 1'b1;
				@(negedge clk);
				data_ack = 1'b0;
			end
			rcv = got;
			if (exp_q.size() == 0)
			begin
				$display("%0t: a sample arrived that the model did not expect", $time);
				errors++;
			end
			else
			begin
				want = exp_q.pop_front();
				compare_value("sample.lost", 64'(rcv.lost), 64'(want.lost));
				compare_value("sample.channels", 64'(rcv.channels), 64'(want.channels));
				compare_value("sample.stamp", 64'(rcv.stamp), 64'(want.stamp));
			end
		end
	endtask

	task automatic check_length(input int want);
		request_length = 1'b1;
		@(negedge clk);
		request_length = 1'b0;
		@(negedge clk);
		compare_value("length", 64'(length), 64'(want));
		if (want != accepted)
		begin
			$display("%0t: stim length %0d differs from model count %0d", $time, want, accepted);
			errors++;
		end
		accepted = 0;
		if (exp_q.size() == 0 && data_rdy)
		begin
			$display("%0t: data_rdy is high with no sample pending", $time);
			errors++;
		end
	endtask

	task automatic measure_period(input int ch, input int p);
		logic prev;
		int n;
		string name;
		n = 0;
		if (p == 0)
		begin
			// once the sequencers are stopped no channel may pulse
			if (seq_on)
				name = $sformatf("laser_en[%0d] high cycles", ch);
			else
				name = "laser_en high cycles";
			repeat (64)
			begin
				@(negedge clk);
				if (seq_on ? laser_en[ch] : (laser_en != '0))
					n++;
			end
			compare_value(name, 64'(n), 64'd0);
			return;
		end
		prev = laser_en[ch];
		while (laser_en[ch] == prev && n < 600)
		begin
			@(negedge clk);
			n++;
		end
		if (laser_en[ch] == prev)
		begin
			$display("%0t: laser_en[%0d] never toggled", $time, ch);
			errors++;
			return;
		end
		prev = laser_en[ch];
		n = 0;
		while (laser_en[ch] == prev && n < 600)
		begin
			@(negedge clk);
			n++;
		end
		compare_value($sformatf("laser_en[%0d] half-period", ch), 64'(n), 64'(p));
	endtask

	initial
	begin
		int fd;
		int code;
		int nargs;
		logic [7:0] op;
		int a;
		int b;
		int i;
		string line;
		rst_n = 1'b0;
		cmd_wr = 1'b0;
		cmd_in = 8'd0;
		request_length = 1'b0;
		data_ack = 1'b0;
		detectors = '0;
		rng = 32'h9714;
		errors = 0;
		checks = 0;
		accepted = 0;
		timer_on = 1'b0;
		seq_on = 1'b0;
		lost_pending = 1'b0;
		clear_ref = 0;
		budget = 0;
		fd = $fopen("verif/timetag_stim.txt", "r");
		if (fd == 0)
		begin
			$display("could not open verif/timetag_stim.txt");
			errors++;
		end
		else
		begin
			while ($fscanf(fd, " %c", op) == 1)
			begin
				if (op == "#")
					code = $fgets(line, fd);
				else
				begin
					a = 0;
					b = 0;
					if (op == "C" || op == "D" || op == "S")
						nargs = 2;
					else
						nargs = 1;
					if (nargs == 2)
						code = $fscanf(fd, " %d %d", a, b);
					else
						code = $fscanf(fd, " %d", a);
					if (code != nargs)
					begin
						$display("stim opcode %c is missing its arguments", op);
						errors++;
					end
					ops.push_back(op);
					arg_a.push_back(a);
					arg_b.push_back(b);
					budget += op_cycles(op, a, b);
				end
			end
			$fclose(fd);
		end
		loaded = 1'b1;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		for (i = 0; i < ops.size(); i++)
			case (ops[i])
				"C": send_command(arg_a[i], arg_b[i]);
				"D": pulse_detector(arg_a[i], arg_b[i]);
				"H": repeat (arg_a[i]) @(negedge clk);
				"R": read_samples(arg_a[i]);
				"Q": check_length(arg_a[i]);
				"S": measure_period(arg_a[i], arg_b[i]);
				default:
				begin
					$display("unknown stim opcode %c", ops[i]);
					errors++;
				end
			endcase
		if (exp_q.size() != 0)
		begin
			$display("%0d expected samples were never read", exp_q.size());
			errors++;
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		wait (loaded);
		#((budget + 2000) * 40);
		$display("timeout: the run went past its cycle budget");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- verif/timetag_stim.txt
# columns: opcode then decimal arguments
# C target data | D mask gap | H cycles | R samples | Q length | S channel half_period
C 2 3
C 3 5
C 4 0
C 5 7
C 1 1
S 0 3
S 1 5
S 2 0
S 3 7
C 1 2
S 0 0
C 0 5
D 1 5
D 6 9
D 8 12
R 3
Q 3
C 0 5
D 15 7
D 2 4
R 2
Q 2
C 0 3
D 3 5
Q 0
H 20
C 0 5
D 1 5
D 2 3
D 4 6
D 8 2
D 3 4
D 5 7
D 6 3
D 9 5
D 15 4
R 8
D 2 5
D 4 6
R 2
Q 10

//--- project.f
hw/timetag_pkg.sv
hw/cmd_parser.sv
hw/run_control.sv
hw/pulse_sequencer.sv
hw/detector_timestamper.sv
hw/sample_buffer.sv
hw/sample_serializer.sv
hw/timetag_top.sv
verif/timetag_sva.sv
verif/timetag_tb.sv

//--- Makefile
SIM = verilator
SIM_FLAGS = --binary --assert -j 0
TOP = timetag_tb
FILE_LIST = project.f
OBJ_DIR = obj_dir
BIN = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
SOURCES = $(shell cat $(FILE_LIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
